// ==== Bender.yml ====
package:
  name: pipe_cpu

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - cpu_pkg.sv
      - pipe_regs.sv
      - decode_stage.sv
      - alu.sv
      - hazard_unit.sv
      - cpu_core.sv
  - target: test
    include_dirs:
      - .
    files:
      - cpu_assert.sv
      - cpu_tb.sv

// ==== all.f ====
+incdir+.
cpu_pkg.sv
pipe_regs.sv
decode_stage.sv
alu.sv
hazard_unit.sv
cpu_core.sv
cpu_assert.sv
cpu_tb.sv

// ==== alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu
	import cpu_pkg::*;
(
	input alu_op_t alu_op,
	input word_t a,
	input word_t b,
	input word_t imm,
	input logic use_imm,
	input logic branch_ne,
	output word_t result,
	output logic bcond
);

	word_t y;

	assign y = use_imm ? imm : b; // Loads and stores take rs + imm

	always_comb begin
		case (alu_op)
			ALU_ADD: result = a + y;
			ALU_SUB: result = a - y;
			ALU_AND: result = a & y;
			ALU_OR: result = a | y;
			ALU_PASS_B: result = y;
			default: result = '0;
		endcase
	end

	// Always on the register operands, never the immediate
	assign bcond = branch_ne ? (a != b) : (a == b);

endmodule

`default_nettype wire

// ==== cpu_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_assert
	import cpu_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic halted,
	input logic dmem_we,
	input logic output_valid,
	input logic stall,
	input word_t imem_addr
);

	int fails = 0;

	// Sticky until reset
	a_halt_sticky: assert property (@(posedge clk) halted && !rst |=> halted)
		else begin
			$error("halted dropped without reset");
			fails++;
		end

	a_quiet_halted: assert property (@(posedge clk) halted |-> !dmem_we && !output_valid)
		else begin
			$error("store or output while halted");
			fails++;
		end

	// Latches clear one edge into reset
	a_quiet_reset: assert property (@(posedge clk) rst |=> !dmem_we && !output_valid)
		else begin
			$error("store or output during reset");
			fails++;
		end

	a_stall_pc: assert property (@(posedge clk) disable iff (rst) stall |=> $stable(imem_addr))
		else begin
			$error("fetch address moved during a stall");
			fails++;
		end

endmodule

bind cpu_core cpu_assert u_assert (
	.clk(clk), .rst(rst), .halted(halted), .dmem_we(dmem_we),
	.output_valid(output_valid), .stall(stall), .imem_addr(imem_addr)
);

`default_nettype wire

// ==== cpu_cfg.svh ====
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// Fixed by the ISA, shared by every stage
`define CPU_WORD_SIZE 16 // Data, instruction and address width

`define CPU_NUM_REGS 4 // Register file depth

`define CPU_RESET_PC 16'h0000 // First fetch after reset

`endif

// ==== cpu_core.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module cpu_core
	import cpu_pkg::*;
(
	input logic clk,
	input logic rst,
	output word_t imem_addr,
	input word_t imem_data,
	output word_t dmem_addr,
	output word_t dmem_wdata,
	output logic dmem_we,
	input word_t dmem_rdata,
	output word_t output_port,
	output logic output_valid,
	output logic halted
);

	word_t pc;
	word_t pc_next;
	word_t pc_plus1;
	word_t br_target;
	logic stall;
	logic flush_if_id;
	logic flush_id_ex;
	logic branch_taken;
	logic jump_taken;
	logic halt_pending;

	word_t id_inst, id_pc, id_a, id_b, id_imm, id_jump_target;
	reg_idx_t id_rs, id_rt, id_dest;
	alu_op_t id_alu_op;
	logic id_valid, id_uses_rs, id_uses_rt, id_reg_write, id_mem_read, id_mem_write;
	logic id_is_wwd, id_is_halt, id_is_branch, id_branch_ne, id_is_jump;

	word_t ex_a, ex_b, ex_imm, ex_pc, ex_result;
	reg_idx_t ex_dest;
	alu_op_t ex_alu_op;
	logic ex_valid, ex_reg_write, ex_mem_read, ex_mem_write, ex_is_wwd, ex_is_halt;
	logic ex_is_branch, ex_branch_ne, ex_bcond;

	word_t mem_alu, mem_b;
	reg_idx_t mem_dest;
	logic mem_valid, mem_reg_write, mem_mem_read, mem_mem_write, mem_is_wwd, mem_is_halt;

	word_t wb_alu, wb_mem, wb_data;
	reg_idx_t wb_dest;
	logic wb_valid, wb_reg_write, wb_mem_read, wb_is_wwd, wb_is_halt, wb_we;

	assign imem_addr = pc;
	assign pc_plus1 = pc + 1'b1;
	assign br_target = ex_pc + ex_imm; // ex_pc is already PC+1
	assign branch_taken = ex_valid && ex_is_branch && ex_bcond;
	assign jump_taken = id_valid && id_is_jump;

	// HLT is committed once past decode, so younger work is dropped
	assign halt_pending = halted || (ex_valid && ex_is_halt) ||
		(mem_valid && mem_is_halt) || (wb_valid && wb_is_halt);

	always_comb begin
		if (branch_taken) begin
			pc_next = br_target;
		end else if (jump_taken) begin
			pc_next = id_jump_target;
		end else if (stall) begin
			pc_next = pc;
		end else begin
			pc_next = pc_plus1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= `CPU_RESET_PC;
		end else if (!halted) begin
			pc <= pc_next;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			halted <= 1'b0;
		end else if (wb_valid && wb_is_halt) begin
			halted <= 1'b1; // Sticky until reset
		end
	end

	if_id_reg u_if_id (
		.clk(clk), .rst(rst), .stall(stall || halted), .flush(flush_if_id && !halted),
		.inst_in(imem_data), .pc_in(pc_plus1),
		.inst(id_inst), .pc(id_pc), .valid(id_valid)
	);

	decode_stage u_decode (
		.clk(clk), .rst(rst), .inst(id_inst), .pc(id_pc),
		.wb_we(wb_we), .wb_dest(wb_dest), .wb_data(wb_data),
		.a(id_a), .b(id_b), .imm(id_imm), .jump_target(id_jump_target),
		.rs(id_rs), .rt(id_rt), .dest(id_dest),
		.uses_rs(id_uses_rs), .uses_rt(id_uses_rt), .alu_op(id_alu_op),
		.reg_write(id_reg_write), .mem_read(id_mem_read), .mem_write(id_mem_write),
		.is_wwd(id_is_wwd), .is_halt(id_is_halt), .is_branch(id_is_branch),
		.branch_ne(id_branch_ne), .is_jump(id_is_jump)
	);

	hazard_unit u_hazard (
		.id_valid(id_valid), .uses_rs(id_uses_rs), .uses_rt(id_uses_rt),
		.rs(id_rs), .rt(id_rt), .is_jump(id_is_jump),
		.ex_valid(ex_valid), .ex_reg_write(ex_reg_write), .ex_dest(ex_dest),
		.mem_valid(mem_valid), .mem_reg_write(mem_reg_write), .mem_dest(mem_dest),
		.branch_taken(branch_taken),
		.stall(stall), .flush_if_id(flush_if_id), .flush_id_ex(flush_id_ex)
	);

	id_ex_reg u_id_ex (
		.clk(clk), .rst(rst), .bubble(stall || halt_pending), .flush(flush_id_ex),
		.a_in(id_a), .b_in(id_b), .imm_in(id_imm), .pc_in(id_pc), .dest_in(id_dest),
		.alu_op_in(id_alu_op), .reg_write_in(id_reg_write), .mem_read_in(id_mem_read),
		.mem_write_in(id_mem_write), .is_wwd_in(id_is_wwd), .is_halt_in(id_is_halt),
		.is_branch_in(id_is_branch), .branch_ne_in(id_branch_ne), .valid_in(id_valid),
		.a(ex_a), .b(ex_b), .imm(ex_imm), .pc(ex_pc), .dest(ex_dest), .alu_op(ex_alu_op),
		.reg_write(ex_reg_write), .mem_read(ex_mem_read), .mem_write(ex_mem_write),
		.is_wwd(ex_is_wwd), .is_halt(ex_is_halt), .is_branch(ex_is_branch),
		.branch_ne(ex_branch_ne), .valid(ex_valid)
	);

	alu u_alu (
		.alu_op(ex_alu_op), .a(ex_a), .b(ex_b), .imm(ex_imm),
		.use_imm(ex_mem_read || ex_mem_write), .branch_ne(ex_branch_ne),
		.result(ex_result), .bcond(ex_bcond)
	);

	ex_mem_reg u_ex_mem (
		.clk(clk), .rst(rst), .alu_in(ex_result), .b_in(ex_b), .dest_in(ex_dest),
		.reg_write_in(ex_reg_write), .mem_read_in(ex_mem_read), .mem_write_in(ex_mem_write),
		.is_wwd_in(ex_is_wwd), .is_halt_in(ex_is_halt), .valid_in(ex_valid),
		.alu_result(mem_alu), .b(mem_b), .dest(mem_dest), .reg_write(mem_reg_write),
		.mem_read(mem_mem_read), .mem_write(mem_mem_write), .is_wwd(mem_is_wwd),
		.is_halt(mem_is_halt), .valid(mem_valid)
	);

	assign dmem_addr = mem_alu;
	assign dmem_wdata = mem_b;
	assign dmem_we = mem_valid && mem_mem_write;

	mem_wb_reg u_mem_wb (
		.clk(clk), .rst(rst), .alu_in(mem_alu), .mem_in(dmem_rdata), .dest_in(mem_dest),
		.reg_write_in(mem_reg_write), .mem_read_in(mem_mem_read), .is_wwd_in(mem_is_wwd),
		.is_halt_in(mem_is_halt), .valid_in(mem_valid),
		.alu_result(wb_alu), .mem_data(wb_mem), .dest(wb_dest), .reg_write(wb_reg_write),
		.mem_read(wb_mem_read), .is_wwd(wb_is_wwd), .is_halt(wb_is_halt), .valid(wb_valid)
	);

	assign wb_data = wb_mem_read ? wb_mem : wb_alu;
	assign wb_we = wb_valid && wb_reg_write && !halted;
	assign output_port = wb_alu; // WWD value passed through the ALU
	assign output_valid = wb_valid && wb_is_wwd;

endmodule

`default_nettype wire

// ==== cpu_pkg.sv ====
`default_nettype none

`include "cpu_cfg.svh"

package cpu_pkg;

	typedef logic [`CPU_WORD_SIZE-1:0] word_t;
	typedef logic [$clog2(`CPU_NUM_REGS)-1:0] reg_idx_t;
	typedef logic [3:0] opcode_t; // Bits 15 to 12
	typedef logic [5:0] funct_t; // R-type only

	localparam opcode_t OP_BNE = 4'd0;
	localparam opcode_t OP_BEQ = 4'd1;
	localparam opcode_t OP_ADI = 4'd4;
	localparam opcode_t OP_LWD = 4'd7;
	localparam opcode_t OP_SWD = 4'd8;
	localparam opcode_t OP_JMP = 4'd9;
	localparam opcode_t OP_RTYPE = 4'd15;

	localparam funct_t FN_ADD = 6'd0;
	localparam funct_t FN_SUB = 6'd1;
	localparam funct_t FN_AND = 6'd2;
	localparam funct_t FN_ORR = 6'd3;
	localparam funct_t FN_WWD = 6'd28;
	localparam funct_t FN_HLT = 6'd29;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_PASS_B // Second operand straight through
	} alu_op_t;

endpackage

`default_nettype wire

// ==== cpu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module cpu_tb
	import cpu_pkg::*;
();

	localparam int NUM_TESTS = 30;
	localparam int PROG_LEN = 32; // Longest program in words
	localparam int IMEM_WORDS = 256;
	localparam int DMEM_WORDS = 64;

	logic clk;
	logic rst;
	word_t imem_addr;
	word_t imem_data;
	word_t dmem_addr;
	word_t dmem_wdata;
	logic dmem_we;
	word_t dmem_rdata;
	word_t output_port;
	logic output_valid;
	logic halted;

	word_t imem [IMEM_WORDS];
	word_t dmem [DMEM_WORDS];
	word_t prog [PROG_LEN];
	word_t exp_mem [DMEM_WORDS];
	word_t exp_out [$];
	word_t got_out [$];
	int plen;
	int exp_count;
	integer seed;
	int errors;
	int addr_errors;
	int passed;
	logic load_dmem;
	int load_tag;

	cpu_core DUT (
		.clk(clk), .rst(rst), .imem_addr(imem_addr), .imem_data(imem_data),
		.dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_we(dmem_we),
		.dmem_rdata(dmem_rdata), .output_port(output_port),
		.output_valid(output_valid), .halted(halted)
	);

	assign imem_data = imem[imem_addr[7:0]];
	assign dmem_rdata = dmem[dmem_addr[5:0]];

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic word_t fill_word(input int addr, input int tag);
		return word_t'(addr * 16'h0b1d + tag * 16'h0137) ^ 16'h5a3c;
	endfunction

	function automatic word_t junk_word(input int addr);
		return word_t'(addr * 16'h02f1) ^ 16'hc3a5; // Never executed
	endfunction

	always @(posedge clk) begin
		if (load_dmem) begin
			for (int i = 0; i < DMEM_WORDS; i++) begin
				dmem[i] <= fill_word(i, load_tag);
			end
		end else if (dmem_we) begin
			dmem[dmem_addr[5:0]] <= dmem_wdata;
		end
	end

	always @(negedge clk) begin
		if (!rst && output_valid) begin
			got_out.push_back(output_port);
		end
		if (dmem_we && dmem_addr >= DMEM_WORDS) begin
			$display("** Error @ %0t ns: store outside the 64-word data area, address %h",
				$time, dmem_addr);
			addr_errors++;
		end
	end

	function automatic int rnd(input int n);
		return $unsigned($random(seed)) % n;
	endfunction

	function automatic word_t r_type_word(funct_t fn, reg_idx_t rs, reg_idx_t rt, reg_idx_t rd);
		return {OP_RTYPE, rs, rt, rd, fn};
	endfunction

	function automatic word_t i_type_word(opcode_t op, reg_idx_t rs, reg_idx_t rt, int imm);
		return {op, rs, rt, imm[7:0]};
	endfunction

	function automatic funct_t pick_funct();
		case (rnd(4))
			0: return FN_ADD;
			1: return FN_SUB;
			2: return FN_AND;
			default: return FN_ORR;
		endcase
	endfunction

	// kind 0 ALU only, 1 loads and stores, 2 branches and jumps
	task automatic make_program(input int kind);
		int n;
		int body_end;
		int pick;
		int span;
		reg_idx_t ra;
		reg_idx_t rb;
		reg_idx_t d;
		opcode_t op;
		n = 0;
		if (kind != 0) begin
			prog[n] = r_type_word(FN_SUB, 2'd3, 2'd3, 2'd3); // r3 = 0, memory base
			n++;
		end
		body_end = n + 12 + rnd(12);
		while (n < body_end) begin
			pick = rnd(8);
			span = body_end - 1 - n;
			ra = reg_idx_t'(rnd(4));
			rb = reg_idx_t'(rnd(4));
			d = reg_idx_t'(rnd(kind == 0 ? 4 : 3)); // r3 stays the base
			if (kind == 0 && pick == 7) begin
				prog[n] = r_type_word(FN_WWD, ra, 2'd0, 2'd0);
			end else if (kind == 1 && pick < 2) begin
				prog[n] = i_type_word(OP_LWD, 2'd3, d, rnd(DMEM_WORDS));
			end else if (kind == 1 && pick < 4) begin
				prog[n] = i_type_word(OP_SWD, 2'd3, ra, rnd(DMEM_WORDS));
			end else if (kind == 1 && pick == 4 && span >= 1) begin
				prog[n] = i_type_word(OP_LWD, 2'd3, d, rnd(DMEM_WORDS));
				n++;
				prog[n] = r_type_word(FN_ADD, d, rb, reg_idx_t'(rnd(3))); // Load-use
			end else if (kind == 2 && pick < 2) begin
				op = rnd(2) ? OP_BEQ : OP_BNE;
				prog[n] = i_type_word(op, ra, rnd(2) ? ra : rb, rnd(4) < span ? rnd(4) : span);
			end else if (kind == 2 && pick == 2) begin
				prog[n] = {OP_JMP, 12'(n + 1 + (rnd(4) < span ? rnd(4) : span))};
			end else if (kind == 2 && pick == 3) begin
				prog[n] = r_type_word(FN_WWD, ra, 2'd0, 2'd0); // May be skipped
			end else if (kind == 2 && pick == 4) begin
				prog[n] = i_type_word(OP_SWD, 2'd3, ra, rnd(DMEM_WORDS));
			end else if (pick < 2 || pick == 5) begin
				prog[n] = i_type_word(OP_ADI, ra, d, rnd(256));
			end else begin
				prog[n] = r_type_word(pick_funct(), ra, rb, d);
			end
			n++;
		end
		for (int r = 0; r < 4; r++) begin
			prog[n] = r_type_word(FN_WWD, reg_idx_t'(r), 2'd0, 2'd0);
			n++;
		end
		prog[n] = r_type_word(FN_HLT, 2'd0, 2'd0, 2'd0);
		plen = n + 1;
	endtask

	// Executes one instruction at a time, in program order
	task automatic run_model(input int t);
		word_t r [4];
		word_t pc;
		word_t npc;
		word_t inst;
		word_t imm;
		word_t addr;
		int steps;
		logic done;
		exp_out.delete();
		exp_count = 0;
		for (int i = 0; i < DMEM_WORDS; i++) begin
			exp_mem[i] = fill_word(i, t);
		end
		r = '{default: '0};
		pc = `CPU_RESET_PC;
		done = 1'b0;
		steps = 0;
		while (!done && steps < PROG_LEN && pc < PROG_LEN) begin
			inst = prog[pc];
			imm = {{8{inst[7]}}, inst[7:0]};
			addr = r[inst[11:10]] + imm;
			npc = pc + 1;
			case (inst[15:12])
				OP_RTYPE: begin
					case (inst[5:0])
						FN_ADD: r[inst[7:6]] = r[inst[11:10]] + r[inst[9:8]];
						FN_SUB: r[inst[7:6]] = r[inst[11:10]] - r[inst[9:8]];
						FN_AND: r[inst[7:6]] = r[inst[11:10]] & r[inst[9:8]];
						FN_ORR: r[inst[7:6]] = r[inst[11:10]] | r[inst[9:8]];
						FN_WWD: exp_out.push_back(r[inst[11:10]]);
						FN_HLT: done = 1'b1;
						default: ;
					endcase
				end
				OP_ADI: r[inst[9:8]] = addr;
				OP_LWD: r[inst[9:8]] = exp_mem[addr[5:0]];
				OP_SWD: exp_mem[addr[5:0]] = r[inst[9:8]];
				OP_BEQ: npc = (r[inst[11:10]] == r[inst[9:8]]) ? npc + imm : npc;
				OP_BNE: npc = (r[inst[11:10]] != r[inst[9:8]]) ? npc + imm : npc;
				OP_JMP: npc = {npc[15:12], inst[11:0]};
				default: ;
			endcase
			exp_count++;
			steps++;
			pc = npc;
		end
	endtask

	task automatic run_test(input int t);
		int base;
		int cycles;
		int bad;
		logic dropped;
		string name;
		bad = 0;
		dropped = 1'b0;
		name = (t % 3 == 0) ? "alu" : (t % 3 == 1) ? "memory" : "branch";
		make_program(t % 3);
		run_model(t);
		for (int i = 0; i < IMEM_WORDS; i++) begin
			imem[i] = (i < plen) ? prog[i] : junk_word(i);
		end
		@(posedge clk);
		rst <= 1'b1;
		load_dmem <= 1'b1;
		load_tag <= t;
		@(posedge clk);
		load_dmem <= 1'b0;
		@(negedge clk);
		if (halted !== 1'b0 || output_valid !== 1'b0 || dmem_we !== 1'b0 ||
			imem_addr !== `CPU_RESET_PC) begin
			$display("** Error @ %0t ns: test %0d reset state halted %b out %b we %b pc %h",
				$time, t, halted, output_valid, dmem_we, imem_addr);
			bad++;
		end
		base = got_out.size();
		@(posedge clk);
		rst <= 1'b0;
		cycles = 0;
		while (halted !== 1'b1 && cycles < 5 * PROG_LEN) begin
			@(negedge clk);
			cycles++;
		end
		if (halted !== 1'b1) begin
			$display("Test %0d never halted within %0d cycles", t, cycles);
			bad++;
		end
		repeat (20) begin
			@(negedge clk);
			dropped = dropped || (halted !== 1'b1);
		end
		if (dropped) begin
			$display("Test %0d: halted dropped after it was set", t);
			bad++;
		end
		if (got_out.size() - base != exp_out.size()) begin
			$display("** Error @ %0t ns: test %0d gave %0d outputs, expected %0d",
				$time, t, got_out.size() - base, exp_out.size());
			bad++;
		end
		for (int i = 0; i < exp_out.size() && base + i < got_out.size(); i++) begin
			if (got_out[base + i] !== exp_out[i]) begin
				$display("** Error @ %0t ns: test %0d output %0d is %h, expected %h",
					$time, t, i, got_out[base + i], exp_out[i]);
				bad++;
			end
		end
		for (int i = 0; i < DMEM_WORDS; i++) begin
			if (dmem[i] !== exp_mem[i]) begin
				$display("** Error @ %0t ns: test %0d dmem[%0d] is %h, expected %h",
					$time, t, i, dmem[i], exp_mem[i]);
				bad++;
			end
		end
		$display("test %0d %s: %0d words, %0d instructions, %0d outputs, %0d cycles, %s",
			t, name, plen, exp_count, exp_out.size(), cycles, bad == 0 ? "ok" : "mismatch");
		errors += bad;
		if (bad == 0) begin
			passed++;
		end
	endtask

	initial begin
		#(NUM_TESTS * 6 * PROG_LEN * 20);
		$display("Watchdog expired before all tests finished");
		$display("Test failed");
		$finish;
	end

	initial begin
		seed = 32'h071a_f17c;
		rst = 1'b1;
		load_dmem = 1'b0;
		load_tag = 0;
		errors = 0;
		addr_errors = 0;
		passed = 0;
		for (int t = 0; t < NUM_TESTS; t++) begin
			run_test(t);
		end
		errors += addr_errors;
		if (DUT.u_assert.fails != 0) begin
			$display("%0d bound assertion failures during the run", DUT.u_assert.fails);
		end
		errors += DUT.u_assert.fails;
		$display("%0d tests, %0d passed, %0d errors", NUM_TESTS, passed, errors);
		if (errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module decode_stage
	import cpu_pkg::*;
(
	input logic clk,
	input logic rst,
	input word_t inst,
	input word_t pc,
	input logic wb_we,
	input reg_idx_t wb_dest,
	input word_t wb_data,
	output word_t a,
	output word_t b,
	output word_t imm,
	output word_t jump_target,
	output reg_idx_t rs,
	output reg_idx_t rt,
	output reg_idx_t dest,
	output logic uses_rs,
	output logic uses_rt,
	output alu_op_t alu_op,
	output logic reg_write,
	output logic mem_read,
	output logic mem_write,
	output logic is_wwd,
	output logic is_halt,
	output logic is_branch,
	output logic branch_ne,
	output logic is_jump
);

	word_t regs [`CPU_NUM_REGS];
	opcode_t opcode;
	funct_t funct;
	reg_idx_t rd;
	word_t rs_val;
	word_t rt_val;

	assign opcode = inst[15:12];
	assign funct = inst[5:0];
	assign rs = inst[11:10];
	assign rt = inst[9:8];
	assign rd = inst[7:6];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `CPU_NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_we) begin
			regs[wb_dest] <= wb_data;
		end
	end

	// Writeback in the same cycle is seen here
	assign rs_val = (wb_we && wb_dest == rs) ? wb_data : regs[rs];
	assign rt_val = (wb_we && wb_dest == rt) ? wb_data : regs[rt];

	assign a = rs_val;
	assign imm = {{(`CPU_WORD_SIZE-8){inst[7]}}, inst[7:0]};
	assign jump_target = {pc[`CPU_WORD_SIZE-1 -: 4], inst[11:0]};

	always_comb begin
		b = rt_val;
		dest = rd;
		alu_op = ALU_ADD;
		{uses_rs, uses_rt, reg_write, mem_read, mem_write} = '0;
		{is_wwd, is_halt, is_branch, branch_ne, is_jump} = '0;
		case (opcode)
			OP_RTYPE: begin
				case (funct)
					FN_ADD, FN_SUB, FN_AND, FN_ORR: begin
						uses_rs = 1'b1;
						uses_rt = 1'b1;
						reg_write = 1'b1;
						alu_op = (funct == FN_SUB) ? ALU_SUB :
							(funct == FN_AND) ? ALU_AND :
							(funct == FN_ORR) ? ALU_OR : ALU_ADD;
					end
					FN_WWD: begin
						uses_rs = 1'b1;
						is_wwd = 1'b1;
						b = rs_val; // Output value rides through the ALU
						alu_op = ALU_PASS_B;
					end
					FN_HLT: is_halt = 1'b1;
					default: ;
				endcase
			end
			OP_ADI: begin
				uses_rs = 1'b1;
				reg_write = 1'b1;
				dest = rt;
				b = imm; // rt is only a destination here
			end
			OP_LWD: begin
				uses_rs = 1'b1;
				reg_write = 1'b1;
				mem_read = 1'b1;
				dest = rt;
			end
			OP_SWD: begin
				uses_rs = 1'b1;
				uses_rt = 1'b1;
				mem_write = 1'b1;
			end
			OP_BNE, OP_BEQ: begin
				uses_rs = 1'b1;
				uses_rt = 1'b1;
				is_branch = 1'b1;
				branch_ne = (opcode == OP_BNE);
			end
			OP_JMP: is_jump = 1'b1;
			default: ; // Unused opcodes act as NOP
		endcase
	end

endmodule

`default_nettype wire

// ==== hazard_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazard_unit
	import cpu_pkg::*;
(
	input logic id_valid,
	input logic uses_rs,
	input logic uses_rt,
	input reg_idx_t rs,
	input reg_idx_t rt,
	input logic is_jump,
	input logic ex_valid,
	input logic ex_reg_write,
	input reg_idx_t ex_dest,
	input logic mem_valid,
	input logic mem_reg_write,
	input reg_idx_t mem_dest,
	input logic branch_taken,
	output logic stall,
	output logic flush_if_id,
	output logic flush_id_ex
);

	logic ex_wr;
	logic mem_wr;
	logic rs_hit;
	logic rt_hit;

	assign ex_wr = ex_valid && ex_reg_write;
	assign mem_wr = mem_valid && mem_reg_write;

	// Writeback is covered by the register file bypass
	assign rs_hit = uses_rs && ((ex_wr && ex_dest == rs) || (mem_wr && mem_dest == rs));
	assign rt_hit = uses_rt && ((ex_wr && ex_dest == rt) || (mem_wr && mem_dest == rt));

	assign stall = id_valid && (rs_hit || rt_hit) && !branch_taken; // Flush overrides
	assign flush_if_id = branch_taken || (id_valid && is_jump);
	assign flush_id_ex = branch_taken;

endmodule

`default_nettype wire

// ==== pipe_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module if_id_reg
	import cpu_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic stall,
	input logic flush,
	input word_t inst_in,
	input word_t pc_in,
	output word_t inst,
	output word_t pc,
	output logic valid
);

	always_ff @(posedge clk) begin
		if (rst || flush) begin
			valid <= 1'b0; // Flush wins over stall
		end else if (!stall) begin
			valid <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			inst <= inst_in;
			pc <= pc_in; // Already PC+1
		end
	end

endmodule

module id_ex_reg
	import cpu_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic bubble,
	input logic flush,
	input word_t a_in,
	input word_t b_in,
	input word_t imm_in,
	input word_t pc_in,
	input reg_idx_t dest_in,
	input alu_op_t alu_op_in,
	input logic reg_write_in,
	input logic mem_read_in,
	input logic mem_write_in,
	input logic is_wwd_in,
	input logic is_halt_in,
	input logic is_branch_in,
	input logic branch_ne_in,
	input logic valid_in,
	output word_t a,
	output word_t b,
	output word_t imm,
	output word_t pc,
	output reg_idx_t dest,
	output alu_op_t alu_op,
	output logic reg_write,
	output logic mem_read,
	output logic mem_write,
	output logic is_wwd,
	output logic is_halt,
	output logic is_branch,
	output logic branch_ne,
	output logic valid
);

	always_ff @(posedge clk) begin
		if (rst || bubble || flush) begin
			valid <= 1'b0;
		end else begin
			valid <= valid_in;
		end
	end

	// Control bits only count while valid is set
	always_ff @(posedge clk) begin
		a <= a_in;
		b <= b_in;
		imm <= imm_in;
		pc <= pc_in;
		dest <= dest_in;
		alu_op <= alu_op_in;
		reg_write <= reg_write_in;
		mem_read <= mem_read_in;
		mem_write <= mem_write_in;
		is_wwd <= is_wwd_in;
		is_halt <= is_halt_in;
		is_branch <= is_branch_in;
		branch_ne <= branch_ne_in;
	end

endmodule

module ex_mem_reg
	import cpu_pkg::*;
(
	input logic clk,
	input logic rst,
	input word_t alu_in,
	input word_t b_in,
	input reg_idx_t dest_in,
	input logic reg_write_in,
	input logic mem_read_in,
	input logic mem_write_in,
	input logic is_wwd_in,
	input logic is_halt_in,
	input logic valid_in,
	output word_t alu_result,
	output word_t b,
	output reg_idx_t dest,
	output logic reg_write,
	output logic mem_read,
	output logic mem_write,
	output logic is_wwd,
	output logic is_halt,
	output logic valid
);

	always_ff @(posedge clk) begin
		if (rst) begin
			valid <= 1'b0;
		end else begin
			valid <= valid_in;
		end
	end

	always_ff @(posedge clk) begin
		alu_result <= alu_in;
		b <= b_in; // Store data
		dest <= dest_in;
		reg_write <= reg_write_in;
		mem_read <= mem_read_in;
		mem_write <= mem_write_in;
		is_wwd <= is_wwd_in;
		is_halt <= is_halt_in;
	end

endmodule

module mem_wb_reg
	import cpu_pkg::*;
(
	input logic clk,
	input logic rst,
	input word_t alu_in,
	input word_t mem_in,
	input reg_idx_t dest_in,
	input logic reg_write_in,
	input logic mem_read_in,
	input logic is_wwd_in,
	input logic is_halt_in,
	input logic valid_in,
	output word_t alu_result,
	output word_t mem_data,
	output reg_idx_t dest,
	output logic reg_write,
	output logic mem_read,
	output logic is_wwd,
	output logic is_halt,
	output logic valid
);

	always_ff @(posedge clk) begin
		if (rst) begin
			valid <= 1'b0;
		end else begin
			valid <= valid_in;
		end
	end

	always_ff @(posedge clk) begin
		alu_result <= alu_in;
		mem_data <= mem_in;
		dest <= dest_in;
		reg_write <= reg_write_in;
		mem_read <= mem_read_in;
		is_wwd <= is_wwd_in;
		is_halt <= is_halt_in;
	end

endmodule

`default_nettype wire
